// File: common/fpga_pkg.sv
package fpga_pkg;

    // Fabric size
    localparam int NUM_TILES = 8;
    localparam int CFG_W     = 32;
    localparam int CFG_AW    = 3;
    localparam int LUT_W     = 16;
    localparam int LUT_IN    = 4;
    localparam int SEL_W     = 3;

    // Caravel user pad count
    localparam int NUM_IO = 38;

    // Word addresses, taken from adr[5:2]
    localparam logic [3:0] ADDR_CFG_LAST = 4'd7;
    localparam logic [3:0] ADDR_PAD_IN   = 4'd8;
    localparam logic [3:0] ADDR_PAD_OUT  = 4'd9;

    // Fixed pad assignment
    localparam int PAD_CCFF_HEAD   = 0;
    localparam int PAD_CCFF_TAIL   = 1;
    localparam int PAD_ISOL_N      = 2;
    localparam int PAD_CCFF_EN     = 3;
    localparam int PAD_FABRIC_BASE = 8;

    // One tile configuration word, select 0 sits in bits 18:16
    typedef struct packed {
        logic [1:0]                   rsvd;
        logic                         reg_en;
        logic                         out_en;
        logic [LUT_IN-1:0][SEL_W-1:0] sel;
        logic [LUT_W-1:0]             lut_mask;
    } tile_cfg_t;

    // Wishbone request from the host
    typedef struct packed {
        logic        stb;
        logic        cyc;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // Wishbone response to the host
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Config bus request, held until granted
    typedef struct packed {
        logic              valid;
        logic              we;
        logic [CFG_AW-1:0] addr;
        logic [CFG_W-1:0]  wdata;
    } cfg_req_t;

    typedef enum logic {
        OWNER_WB,
        OWNER_CCFF
    } cfg_owner_e;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_WAIT_GNT,
        WB_WAIT_RD,
        WB_ACK
    } wb_state_e;

endpackage

// File: fabric/cfg_mem.sv
`timescale 1ns/1ps

module cfg_mem import fpga_pkg::*; (
    input  logic                      wb_clk_i,
    input  logic                      reset_i,
    input  cfg_req_t                  mem_req_i,
    output logic [CFG_W-1:0]          rd_data_o,
    output tile_cfg_t [NUM_TILES-1:0] tile_cfg_o
);

    tile_cfg_t [NUM_TILES-1:0] mem_q;

    // Cleared words leave every tile as an undriven input
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            mem_q <= '0;
        end else if (mem_req_i.valid && mem_req_i.we) begin
            mem_q[mem_req_i.addr] <= tile_cfg_t'(mem_req_i.wdata);
        end
    end

    // Read data appears the cycle after the grant
    always_ff @(posedge wb_clk_i) begin
        if (mem_req_i.valid && !mem_req_i.we) begin
            rd_data_o <= mem_q[mem_req_i.addr];
        end
    end

    // All words feed the tiles in parallel
    assign tile_cfg_o = mem_q;

endmodule

// File: fabric/io_tile_array.sv
`timescale 1ns/1ps

module io_tile_array import fpga_pkg::*; (
    input  logic                      wb_clk_i,
    input  logic                      reset_i,
    input  tile_cfg_t [NUM_TILES-1:0] tile_cfg_i,
    input  logic [NUM_TILES-1:0]      pad_in_i,
    input  logic                      isol_n_i,
    output logic [NUM_TILES-1:0]      pad_out_o,
    output logic [NUM_TILES-1:0]      pad_oeb_o
);

    for (genvar t = 0; t < NUM_TILES; t++) begin : g_tile
        logic [LUT_IN-1:0] lut_idx;
        logic              lut_val;
        logic              out_q;

        // Select 0 drives the lowest index bit
        always_comb begin
            for (int i = 0; i < LUT_IN; i++) begin
                lut_idx[i] = pad_in_i[tile_cfg_i[t].sel[i]];
            end
        end

        assign lut_val = tile_cfg_i[t].lut_mask[lut_idx];

        // Optional output flop
        always_ff @(posedge wb_clk_i) begin
            if (reset_i) begin
                out_q <= 1'b0;
            end else begin
                out_q <= lut_val;
            end
        end

        // Value always visible, even when not driven onto the pad
        assign pad_out_o[t] = tile_cfg_i[t].reg_en ? out_q : lut_val;

        // Isolation forces every fabric pad to input
        assign pad_oeb_o[t] = !isol_n_i || !tile_cfg_i[t].out_en;
    end

endmodule

// File: design/wb_cfg_port.sv
`timescale 1ns/1ps

module wb_cfg_port import fpga_pkg::*; (
    input  logic                 wb_clk_i,
    input  logic                 reset_i,
    input  wb_req_t              wbs_i,
    output wb_rsp_t              wbs_o,
    output cfg_req_t             cfg_req_o,
    input  logic                 cfg_gnt_i,
    input  logic [CFG_W-1:0]     cfg_rd_data_i,
    input  logic [NUM_TILES-1:0] pad_in_i,
    input  logic [NUM_TILES-1:0] pad_out_i
);

    wb_state_e         state_q;
    logic [3:0]        word_addr;
    logic              upper_zero;
    logic              is_cfg;
    logic              start;
    logic [CFG_W-1:0]  status_data;
    logic [CFG_AW-1:0] addr_q;
    logic              we_q;
    logic [CFG_W-1:0]  wdata_q;
    logic [CFG_W-1:0]  rdata_q;

    // Address bits above the word field must be zero for a mapped hit
    assign word_addr  = wbs_i.adr[5:2];
    assign upper_zero = (wbs_i.adr[31:6] == '0);
    assign is_cfg     = upper_zero && (word_addr <= ADDR_CFG_LAST);
    assign start      = wbs_i.stb && wbs_i.cyc;

    // Status words answer directly, unmapped reads give zero
    always_comb begin
        status_data = '0;
        if (upper_zero && word_addr == ADDR_PAD_IN) begin
            status_data[NUM_TILES-1:0] = pad_in_i;
        end else if (upper_zero && word_addr == ADDR_PAD_OUT) begin
            status_data[NUM_TILES-1:0] = pad_out_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q <= WB_IDLE;
        end else begin
            case (state_q)
                WB_IDLE: begin
                    if (start) begin
                        state_q <= is_cfg ? WB_WAIT_GNT : WB_ACK;
                    end
                end
                // Writes finish on the grant edge, reads need one more cycle
                WB_WAIT_GNT: begin
                    if (cfg_gnt_i) begin
                        state_q <= we_q ? WB_ACK : WB_WAIT_RD;
                    end
                end
                WB_WAIT_RD: state_q <= WB_ACK;
                default:    state_q <= WB_IDLE;
            endcase
        end
    end

    // Captured request and response data
    always_ff @(posedge wb_clk_i) begin
        if (state_q == WB_IDLE && start) begin
            addr_q  <= word_addr[CFG_AW-1:0];
            we_q    <= wbs_i.we;
            // Byte selects ignored, whole word replaced
            wdata_q <= wbs_i.dat;
            rdata_q <= status_data;
        end else if (state_q == WB_WAIT_RD) begin
            rdata_q <= cfg_rd_data_i;
        end
    end

    assign cfg_req_o.valid = (state_q == WB_WAIT_GNT);
    assign cfg_req_o.we    = we_q;
    assign cfg_req_o.addr  = addr_q;
    assign cfg_req_o.wdata = wdata_q;

    assign wbs_o.ack = (state_q == WB_ACK);
    assign wbs_o.dat = rdata_q;

endmodule

// File: design/ccff_loader.sv
`timescale 1ns/1ps

module ccff_loader import fpga_pkg::*; (
    input  logic     wb_clk_i,
    input  logic     reset_i,
    input  logic     ccff_en_i,
    input  logic     ccff_head_i,
    output logic     ccff_tail_o,
    output cfg_req_t cfg_req_o,
    input  logic     cfg_gnt_i
);

    logic [CFG_W-1:0]         shift_q;
    logic [$clog2(CFG_W)-1:0] bit_cnt_q;
    logic [CFG_AW-1:0]        word_cnt_q;
    logic                     word_done;
    logic                     req_valid_q;
    logic [CFG_AW-1:0]        req_addr_q;
    logic [CFG_W-1:0]         req_data_q;

    // Last bit of a word arrives this cycle
    assign word_done = ccff_en_i && (bit_cnt_q == CFG_W - 1);

    // Chain shift, MSB first, tail is the bit pushed out
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            shift_q     <= '0;
            ccff_tail_o <= 1'b0;
        end else if (ccff_en_i) begin
            shift_q     <= {shift_q[CFG_W-2:0], ccff_head_i};
            ccff_tail_o <= shift_q[CFG_W-1];
        end
    end

    // Bit and word counters restart whenever the chain is disabled
    always_ff @(posedge wb_clk_i) begin
        if (reset_i || !ccff_en_i) begin
            bit_cnt_q  <= '0;
            word_cnt_q <= '0;
        end else begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (word_done) begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end
        end
    end

    // Pending request, a fresh word wins over a same-cycle grant
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            req_valid_q <= 1'b0;
        end else if (word_done) begin
            req_valid_q <= 1'b1;
        end else if (cfg_gnt_i) begin
            req_valid_q <= 1'b0;
        end
    end

    // Own copy of the word so shifting may go on while waiting
    always_ff @(posedge wb_clk_i) begin
        if (word_done) begin
            req_addr_q <= word_cnt_q;
            req_data_q <= {shift_q[CFG_W-2:0], ccff_head_i};
        end
    end

    assign cfg_req_o.valid = req_valid_q;
    assign cfg_req_o.we    = 1'b1;
    assign cfg_req_o.addr  = req_addr_q;
    assign cfg_req_o.wdata = req_data_q;

endmodule

// File: design/cfg_arbiter.sv
`timescale 1ns/1ps

module cfg_arbiter import fpga_pkg::*; (
    input  logic     wb_clk_i,
    input  logic     reset_i,
    input  cfg_req_t wb_req_i,
    input  cfg_req_t ccff_req_i,
    output logic     wb_gnt_o,
    output logic     ccff_gnt_o,
    output cfg_req_t mem_req_o
);

    cfg_owner_e last_q;

    // On a tie the requester that did not win last time goes first
    assign wb_gnt_o   = wb_req_i.valid
                        && (!ccff_req_i.valid || last_q == OWNER_CCFF);
    assign ccff_gnt_o = ccff_req_i.valid
                        && (!wb_req_i.valid || last_q == OWNER_WB);

    // Winner's request goes to memory, valid only when granted
    always_comb begin
        mem_req_o       = ccff_gnt_o ? ccff_req_i : wb_req_i;
        mem_req_o.valid = wb_gnt_o || ccff_gnt_o;
    end

    // Host gets first turn after reset
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            last_q <= OWNER_CCFF;
        end else if (wb_gnt_o) begin
            last_q <= OWNER_WB;
        end else if (ccff_gnt_o) begin
            last_q <= OWNER_CCFF;
        end
    end

endmodule

// File: design/caravel_fpga_wrapper.sv
`timescale 1ns/1ps

module caravel_fpga_wrapper import fpga_pkg::*; (
    input  logic              wb_clk_i,
    input  logic              reset_i,
    input  wb_req_t           wbs_i,
    output wb_rsp_t           wbs_o,
    input  logic [NUM_IO-1:0] io_in_i,
    output logic [NUM_IO-1:0] io_out_o,
    output logic [NUM_IO-1:0] io_oeb_o
);

    // Config bus between the requesters, arbiter and memory
    cfg_req_t                    wb_cfg_req;
    cfg_req_t                    ccff_cfg_req;
    cfg_req_t                    mem_req;
    logic                        wb_gnt;
    logic                        ccff_gnt;
    logic [CFG_W-1:0]            cfg_rd_data;
    tile_cfg_t [NUM_TILES-1:0]   tile_cfg;

    // Fabric side of the pads
    logic [NUM_TILES-1:0] fabric_in;
    logic [NUM_TILES-1:0] fabric_out;
    logic [NUM_TILES-1:0] fabric_oeb;
    logic                 ccff_tail;

    assign fabric_in = io_in_i[PAD_FABRIC_BASE +: NUM_TILES];

    // Unused pads stay inputs driving zero
    always_comb begin
        io_out_o = '0;
        io_oeb_o = '1;
        io_out_o[PAD_FABRIC_BASE +: NUM_TILES] = fabric_out;
        io_oeb_o[PAD_FABRIC_BASE +: NUM_TILES] = fabric_oeb;
        // Chain tail is the only fixed output pad
        io_out_o[PAD_CCFF_TAIL] = ccff_tail;
        io_oeb_o[PAD_CCFF_TAIL] = 1'b0;
    end

    wb_cfg_port i_wb_cfg_port (
        .wb_clk_i      (wb_clk_i),
        .reset_i       (reset_i),
        .wbs_i         (wbs_i),
        .wbs_o         (wbs_o),
        .cfg_req_o     (wb_cfg_req),
        .cfg_gnt_i     (wb_gnt),
        .cfg_rd_data_i (cfg_rd_data),
        .pad_in_i      (fabric_in),
        .pad_out_i     (fabric_out)
    );

    ccff_loader i_ccff_loader (
        .wb_clk_i    (wb_clk_i),
        .reset_i     (reset_i),
        .ccff_en_i   (io_in_i[PAD_CCFF_EN]),
        .ccff_head_i (io_in_i[PAD_CCFF_HEAD]),
        .ccff_tail_o (ccff_tail),
        .cfg_req_o   (ccff_cfg_req),
        .cfg_gnt_i   (ccff_gnt)
    );

    cfg_arbiter i_cfg_arbiter (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .wb_req_i   (wb_cfg_req),
        .ccff_req_i (ccff_cfg_req),
        .wb_gnt_o   (wb_gnt),
        .ccff_gnt_o (ccff_gnt),
        .mem_req_o  (mem_req)
    );

    cfg_mem i_cfg_mem (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .mem_req_i  (mem_req),
        .rd_data_o  (cfg_rd_data),
        .tile_cfg_o (tile_cfg)
    );

    io_tile_array i_io_tile_array (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .tile_cfg_i (tile_cfg),
        .pad_in_i   (fabric_in),
        .isol_n_i   (io_in_i[PAD_ISOL_N]),
        .pad_out_o  (fabric_out),
        .pad_oeb_o  (fabric_oeb)
    );

endmodule

// File: testbench/fpga_checker.sv
`timescale 1ns/1ps

module fpga_checker import fpga_pkg::*; (
    input logic              clk_i,
    input logic              reset_i,
    input wb_req_t           wb_req_i,
    input wb_rsp_t           wb_rsp_i,
    input logic              wb_gnt_i,
    input logic              ccff_gnt_i,
    input logic [NUM_IO-1:0] io_in_i,
    input logic [NUM_IO-1:0] io_oeb_i
);

    // Ack is a one-cycle pulse
    ack_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else $error("Wishbone ack high for two cycles in a row");

    // Only inside an active bus cycle
    ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_rsp_i.ack |-> (wb_req_i.stb && wb_req_i.cyc))
        else $error("Wishbone ack without stb and cyc");

    // Arbiter never grants both requesters
    grant_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
        !(wb_gnt_i && ccff_gnt_i))
        else $error("Both config bus grants high");

    // Isolation turns every fabric pad into an input
    isolation_oeb: assert property (@(posedge clk_i) disable iff (reset_i)
        !io_in_i[PAD_ISOL_N] |-> &io_oeb_i[PAD_FABRIC_BASE +: NUM_TILES])
        else $error("Fabric pad driven while isolated");

endmodule

// File: testbench/tb_caravel_fpga.sv
`timescale 1ns/1ps

module tb_caravel_fpga import fpga_pkg::*; ();

    // Cycles allowed for any single Wishbone handshake
    localparam int WAIT_LIMIT = 40;

    logic              clk;
    logic              reset;
    wb_req_t           wbs_req;
    wb_rsp_t           wbs_rsp;
    logic [NUM_IO-1:0] io_in;
    logic [NUM_IO-1:0] io_out;
    logic [NUM_IO-1:0] io_oeb;

    // Expected config words as the host or chain last wrote them
    logic [CFG_W-1:0]     shadow [NUM_TILES];
    logic [CFG_W-1:0]     chain_words [NUM_TILES];
    logic [NUM_TILES-1:0] prev_in;
    // Every head bit shifted in with the oldest at index 0
    logic                 head_hist [$];
    logic                 check_en;
    logic                 chain_done;
    int                   mismatch_count;
    int                   other_count;

    always #10 clk = ~clk;

    caravel_fpga_wrapper i_dut (
        .wb_clk_i (clk),
        .reset_i  (reset),
        .wbs_i    (wbs_req),
        .wbs_o    (wbs_rsp),
        .io_in_i  (io_in),
        .io_out_o (io_out),
        .io_oeb_o (io_oeb)
    );

    bind caravel_fpga_wrapper fpga_checker i_checker (
        .clk_i      (wb_clk_i),
        .reset_i    (reset_i),
        .wb_req_i   (wbs_i),
        .wb_rsp_i   (wbs_o),
        .wb_gnt_i   (wb_gnt),
        .ccff_gnt_i (ccff_gnt),
        .io_in_i    (io_in_i),
        .io_oeb_i   (io_oeb_o)
    );

    // LUT value of one tile where select i picks the pad for index bit i
    function automatic logic tile_value(input logic [CFG_W-1:0] cfg,
                                        input logic [NUM_TILES-1:0] pins);
        logic [3:0] idx;
        for (int i = 0; i < 4; i++) begin
            idx[i] = pins[cfg[16 + 3 * i +: 3]];
        end
        return cfg[idx];
    endfunction

    // Pad is an input unless enabled and not isolated
    function automatic logic tile_oeb(input logic [CFG_W-1:0] cfg, input logic isol_n);
        return !isol_n || !cfg[28];
    endfunction

    task automatic check_value(input string name, input logic [NUM_IO-1:0] got,
                               input logic [NUM_IO-1:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Polls ack at falling edges where it is stable
    task automatic wait_ack(input logic [31:0] adr, output logic seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            seen = wbs_rsp.ack;
        end
        assert (seen) else begin
            other_count++;
            $display("Error at %0t: no Wishbone ack for address %h", $time, adr);
        end
    endtask

    task automatic write_word(input logic [31:0] adr, input logic [31:0] dat);
        logic seen;
        wbs_req = '{stb: 1'b1, cyc: 1'b1, we: 1'b1, sel: 4'hf, adr: adr, dat: dat};
        wait_ack(adr, seen);
        // Drop the request in the cycle after ack
        @(posedge clk);
        #2;
        wbs_req = '0;
        // Bus stays idle for one edge before the next access
        @(posedge clk);
        #2;
    endtask

    task automatic read_word(input logic [31:0] adr, output logic [31:0] data);
        logic seen;
        wbs_req = '{stb: 1'b1, cyc: 1'b1, we: 1'b0, sel: 4'hf, adr: adr, dat: '0};
        wait_ack(adr, seen);
        data = wbs_rsp.dat;
        @(posedge clk);
        #2;
        wbs_req = '0;
        @(posedge clk);
        #2;
    endtask

    // Pad compare paused while the word changes inside the DUT
    task automatic load_config(input int idx, input logic [CFG_W-1:0] data);
        check_en = 1'b0;
        write_word(idx * 4, data);
        shadow[idx] = data;
        check_en    = 1'b1;
    endtask

    task automatic drive_pads(input int cycles);
        repeat (cycles) begin
            io_in[PAD_FABRIC_BASE +: NUM_TILES] = NUM_TILES'($urandom);
            @(posedge clk);
            #2;
        end
    endtask

    // Word 0 goes in first and each word MSB first
    task automatic shift_chain();
        for (int w = 0; w < NUM_TILES; w++) begin
            for (int b = CFG_W - 1; b >= 0; b--) begin
                io_in[PAD_CCFF_EN]   = 1'b1;
                io_in[PAD_CCFF_HEAD] = chain_words[w][b];
                @(posedge clk);
                #2;
            end
        end
        io_in[PAD_CCFF_EN]   = 1'b0;
        io_in[PAD_CCFF_HEAD] = 1'b0;
        chain_done           = 1'b1;
    endtask

    always @(posedge clk) begin
        if (!reset && io_in[PAD_CCFF_EN]) begin
            head_hist.push_back(io_in[PAD_CCFF_HEAD]);
        end
    end

    // Pad outputs checked against the reference at every falling edge
    always @(negedge clk) begin : compare_pads
        logic [NUM_IO-1:0]    exp_out;
        logic [NUM_IO-1:0]    exp_oeb;
        logic [NUM_TILES-1:0] pins;
        logic                 exp_tail;
        pins = io_in[PAD_FABRIC_BASE +: NUM_TILES];
        if (!reset) begin
            // Tail is the head bit from 32 shifts back
            exp_tail = (head_hist.size() > CFG_W) ?
                       head_hist[head_hist.size() - CFG_W - 1] : 1'b0;
            check_value("io_out_o[1]", io_out[PAD_CCFF_TAIL], exp_tail);
            if (check_en) begin
                exp_out = '0;
                exp_oeb = '1;
                exp_out[PAD_CCFF_TAIL] = exp_tail;
                exp_oeb[PAD_CCFF_TAIL] = 1'b0;
                for (int t = 0; t < NUM_TILES; t++) begin
                    // Registered tiles show last cycle's pads
                    exp_out[PAD_FABRIC_BASE + t] = shadow[t][29] ?
                        tile_value(shadow[t], prev_in) : tile_value(shadow[t], pins);
                    exp_oeb[PAD_FABRIC_BASE + t] = tile_oeb(shadow[t], io_in[PAD_ISOL_N]);
                end
                check_value("io_out_o", io_out, exp_out);
                check_value("io_oeb_o", io_oeb, exp_oeb);
            end
        end
        prev_in = pins;
    end

    initial begin : stimulus
        logic [31:0]          data;
        logic [31:0]          cfg;
        logic [NUM_TILES-1:0] exp_vals;
        int                   rd_idx;
        void'($urandom(32'h8bf8));
        clk            = 1'b0;
        reset          = 1'b1;
        wbs_req        = '0;
        io_in          = '0;
        prev_in        = '0;
        check_en       = 1'b0;
        chain_done     = 1'b0;
        mismatch_count = 0;
        other_count    = 0;
        for (int i = 0; i < NUM_TILES; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        reset             = 1'b0;
        io_in[PAD_ISOL_N] = 1'b1;
        check_en          = 1'b1;

        // Reset state and cleared config words
        check_value("wbs_o.ack", wbs_rsp.ack, 1'b0);
        for (int i = 0; i < NUM_TILES; i++) begin
            read_word(i * 4, data);
            check_value($sformatf("wbs_o.dat word %0d", i), data, '0);
        end

        // Combinational tiles with reserved and register bits clear
        for (int i = 0; i < NUM_TILES; i++) begin
            cfg = $urandom & 32'h1fff_ffff;
            load_config(i, cfg);
            read_word(i * 4, data);
            check_value($sformatf("wbs_o.dat word %0d", i), data, cfg);
        end
        drive_pads(20);

        // Same LUTs through the output register
        for (int i = 0; i < NUM_TILES; i++) begin
            load_config(i, shadow[i] | 32'h2000_0000);
        end
        drive_pads(20);

        // Isolation on and then off
        io_in[PAD_ISOL_N] = 1'b0;
        drive_pads(10);
        io_in[PAD_ISOL_N] = 1'b1;
        drive_pads(10);

        // Status words with pads held long enough for the registers
        drive_pads(1);
        @(posedge clk);
        #2;
        read_word({26'd0, ADDR_PAD_IN, 2'b00}, data);
        check_value("wbs_o.dat status 8", data, io_in[PAD_FABRIC_BASE +: NUM_TILES]);
        for (int t = 0; t < NUM_TILES; t++) begin
            exp_vals[t] = tile_value(shadow[t], io_in[PAD_FABRIC_BASE +: NUM_TILES]);
        end
        read_word({26'd0, ADDR_PAD_OUT, 2'b00}, data);
        check_value("wbs_o.dat status 9", data, exp_vals);

        // Chain load while the host keeps reading
        for (int w = 0; w < NUM_TILES; w++) begin
            chain_words[w] = $urandom;
        end
        check_en   = 1'b0;
        chain_done = 1'b0;
        fork
            shift_chain();
            begin
                while (!chain_done) begin
                    rd_idx = $urandom % NUM_TILES;
                    read_word(rd_idx * 4, data);
                end
            end
        join
        // Last chain write is granted within two cycles
        repeat (4) @(posedge clk);
        #2;
        for (int i = 0; i < NUM_TILES; i++) begin
            shadow[i] = chain_words[i];
        end
        check_en = 1'b1;
        for (int i = 0; i < NUM_TILES; i++) begin
            read_word(i * 4, data);
            check_value($sformatf("wbs_o.dat word %0d", i), data, chain_words[i]);
        end

        // Unmapped words above the status words and with high address bits set
        read_word(32'h28, data);
        check_value("wbs_o.dat unmapped 0x28", data, '0);
        write_word(32'h28, $urandom);
        write_word(32'h100, $urandom);
        read_word(32'h100, data);
        check_value("wbs_o.dat unmapped 0x100", data, '0);
        for (int i = 0; i < NUM_TILES; i++) begin
            read_word(i * 4, data);
            check_value($sformatf("wbs_o.dat word %0d", i), data, shadow[i]);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: files.f
common/fpga_pkg.sv
fabric/cfg_mem.sv
fabric/io_tile_array.sv
design/wb_cfg_port.sv
design/ccff_loader.sv
design/cfg_arbiter.sv
design/caravel_fpga_wrapper.sv
testbench/fpga_checker.sv
testbench/tb_caravel_fpga.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_caravel_fpga -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_caravel_fpga)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
